// ==== src/ac97_pkg.sv ====
package ac97_pkg;

  ////////////////////////////////////////////////////////////
  // widths and payload types
  ////////////////////////////////////////////////////////////

  typedef logic [17:0] sample_t;
  typedef logic [19:0] slot_word_t;
  typedef logic [4:0]  volume_t;
  typedef logic [7:0]  cmd_addr_t;
  typedef logic [15:0] cmd_data_t;
  // position within a 256-bit frame
  typedef logic [7:0]  bit_pos_t;
  typedef logic [9:0]  reset_count_t;
  // wide enough for the default interval
  typedef logic [18:0] debounce_count_t;

  // one codec register access
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      valid;
  } codec_cmd_t;

  // everything sent in one frame
  typedef struct packed {
    codec_cmd_t cmd;
    slot_word_t left;
    slot_word_t right;
  } slot_out_t;

  // capture slots 3 and 4
  typedef struct packed {
    slot_word_t left;
    slot_word_t right;
  } slot_in_t;

  ////////////////////////////////////////////////////////////
  // frame layout and timing
  ////////////////////////////////////////////////////////////

  localparam int       frame_bits       = 256;
  localparam bit_pos_t frame_last       = bit_pos_t'(frame_bits - 1);
  localparam bit_pos_t sync_bits        = 8'd16;
  localparam bit_pos_t slot_bits        = 8'd20;
  localparam bit_pos_t slot_addr_first  = 8'd16;
  localparam bit_pos_t slot_data_first  = 8'd36;
  localparam bit_pos_t slot_left_first  = 8'd56;
  localparam bit_pos_t slot_right_first = 8'd76;
  localparam bit_pos_t ready_rise       = 8'd128;
  localparam bit_pos_t ready_fall       = 8'd2;

  localparam int              codec_reset_cycles      = 1024;
  // about 10 ms at 27 MHz
  localparam debounce_count_t debounce_cycles_default = 19'd270000;

  ////////////////////////////////////////////////////////////
  // volume and codec registers
  ////////////////////////////////////////////////////////////

  localparam volume_t    volume_reset      = 5'd24;
  localparam volume_t    volume_max        = 5'd31;
  localparam logic [2:0] record_source_mic = 3'd4;

  localparam cmd_addr_t reg_read_id       = 8'h80;
  localparam cmd_addr_t reg_headphone     = 8'h04;
  localparam cmd_addr_t reg_pcm_volume    = 8'h18;
  localparam cmd_addr_t reg_record_select = 8'h1A;
  localparam cmd_addr_t reg_record_gain   = 8'h1C;
  localparam cmd_addr_t reg_mic_gain      = 8'h0E;
  localparam cmd_addr_t reg_beep          = 8'h0A;
  localparam cmd_addr_t reg_general       = 8'h20;

  // pcm out at 0 dB, max record gain, +20 dB mic, beep off, mix1 bypass
  localparam cmd_data_t val_pcm_volume  = 16'h0808;
  localparam cmd_data_t val_record_gain = 16'h0F0F;
  localparam cmd_data_t val_mic_gain    = 16'h8048;
  localparam cmd_data_t val_beep        = 16'h0000;
  localparam cmd_data_t val_general     = 16'h8000;

endpackage

// ==== src/switch_debounce.sv ====
`timescale 1ns/1ns

module switch_debounce #(
  parameter ac97_pkg::debounce_count_t debounce_cycles = ac97_pkg::debounce_cycles_default
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  import ac97_pkg::*;

  // cycles the last sample has been stable
  debounce_count_t count;
  // last sample of the raw input
  logic            sample;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      // start out agreeing with the pin
      count  <= '0;
      sample <= noisy;
      clean  <= noisy;
    end else if (noisy != sample) begin
      // input moved, restart interval
      sample <= noisy;
      count  <= '0;
    end else if (count == debounce_cycles) begin
      // stable long enough
      clean <= sample;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== src/volume_control.sv ====
`timescale 1ns/1ns

module volume_control #(
  parameter ac97_pkg::debounce_count_t debounce_cycles = ac97_pkg::debounce_cycles_default
) (
  input  logic              clock_27mhz,
  input  logic              reset,
  input  logic              button_up,
  input  logic              button_down,
  output ac97_pkg::volume_t volume
);

  import ac97_pkg::*;

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  // buttons are active low, so filter the inverted pins
  switch_debounce #(.debounce_cycles(debounce_cycles)) i_up_debounce (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_up),
    .clean       (up_clean)
  );

  switch_debounce #(.debounce_cycles(debounce_cycles)) i_down_debounce (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_down),
    .clean       (down_clean)
  );

  // one step per press
  assign up_edge   = up_clean & ~up_prev;
  assign down_edge = down_clean & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    // follow clean levels even in reset so a held button does not step
    up_prev   <= up_clean;
    down_prev <= down_clean;
    if (reset) begin
      volume <= volume_reset;
    end else if (up_edge && !down_edge && volume != volume_max) begin
      volume <= volume + 1'b1;
    end else if (down_edge && !up_edge && volume != '0) begin
      volume <= volume - 1'b1;
    end
  end

endmodule

// ==== src/codec_command_sequencer.sv ====
`timescale 1ns/1ns

module codec_command_sequencer (
  input  logic                 clock_27mhz,
  input  logic                 reset,
  input  logic                 frame_strobe,
  input  ac97_pkg::volume_t    volume,
  output ac97_pkg::codec_cmd_t command
);

  import ac97_pkg::*;

  // one state per frame, 16 in the loop
  typedef enum logic [3:0] {
    st_read_id0,
    st_read_id1,
    st_spare2,
    st_headphone,
    st_spare4,
    st_pcm_volume,
    st_record_select,
    st_record_gain,
    st_spare8,
    st_mic_gain,
    st_beep,
    st_general,
    st_spare12,
    st_spare13,
    st_spare14,
    st_spare15
  } state_t;

  state_t  state;
  // codec wants attenuation, not gain
  volume_t attenuation;

  assign attenuation = volume_max - volume;

  ////////////////////////////////////////////////////////////
  // state walk and command table
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state   <= st_read_id0;
      command <= '0;
    end else begin
      if (frame_strobe) begin
        // wraps after st_spare15
        state <= state_t'(state + 4'd1);
      end
      // valid from the first pass on
      if (state == st_read_id0) begin
        command.valid <= 1'b1;
      end
      case (state)
        st_headphone: begin
          // same attenuation both channels
          command.addr <= reg_headphone;
          command.data <= {3'b000, attenuation, 3'b000, attenuation};
        end
        st_pcm_volume: begin
          command.addr <= reg_pcm_volume;
          command.data <= val_pcm_volume;
        end
        st_record_select: begin
          command.addr <= reg_record_select;
          command.data <= {5'b00000, record_source_mic, 5'b00000, record_source_mic};
        end
        st_record_gain: begin
          command.addr <= reg_record_gain;
          command.data <= val_record_gain;
        end
        st_mic_gain: begin
          command.addr <= reg_mic_gain;
          command.data <= val_mic_gain;
        end
        st_beep: begin
          command.addr <= reg_beep;
          command.data <= val_beep;
        end
        st_general: begin
          command.addr <= reg_general;
          command.data <= val_general;
        end
        default: begin
          // gap states just read the vendor id
          command.addr <= reg_read_id;
          command.data <= '0;
        end
      endcase
    end
  end

endmodule

// ==== src/ac97_frame_engine.sv ====
`timescale 1ns/1ns

module ac97_frame_engine (
  input  logic                ac97_bit_clock,
  input  logic                reset,
  input  ac97_pkg::slot_out_t slots_out,
  output ac97_pkg::slot_in_t  slots_in,
  output logic                frame_ready,
  output logic                ac97_sdata_out,
  input  logic                ac97_sdata_in,
  output logic                ac97_synch
);

  import ac97_pkg::*;

  // reset brought into the bit-clock domain
  logic [1:0] reset_sync;
  logic       engine_reset;

  bit_pos_t   bit_count;
  // slot contents held for one whole frame
  slot_out_t  frame_slots;
  // playback tags, off for the first frame
  logic       audio_valid;
  // serializer for slots 1 to 4
  slot_word_t shift_word;

  always_ff @(posedge ac97_bit_clock) begin
    reset_sync <= {reset_sync[0], reset};
  end

  assign engine_reset = reset_sync[1];

  ////////////////////////////////////////////////////////////
  // frame counter, sync and ready
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (engine_reset) begin
      bit_count                 <= '0;
      ac97_synch                <= 1'b0;
      frame_ready               <= 1'b0;
      audio_valid               <= 1'b0;
      frame_slots.cmd.valid     <= 1'b0;
    end else begin
      bit_count <= bit_count + 8'd1;

      // synch covers bits 0 to 15 of the next frame
      if (bit_count == frame_last) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == sync_bits - 8'd1) begin
        ac97_synch <= 1'b0;
      end

      // ready high from mid frame into the next
      if (bit_count == ready_rise) begin
        frame_ready <= 1'b1;
      end else if (bit_count == ready_fall) begin
        frame_ready <= 1'b0;
      end

      // take user data at frame end
      if (bit_count == frame_last) begin
        frame_slots <= slots_out;
        audio_valid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // serial out, msb first
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    // load each slot the bit before it starts
    case (bit_count)
      slot_addr_first - 8'd1:
        shift_word <= frame_slots.cmd.valid ? {frame_slots.cmd.addr, 12'h000} : '0;
      slot_data_first - 8'd1:
        shift_word <= frame_slots.cmd.valid ? {frame_slots.cmd.data, 4'h0} : '0;
      slot_left_first - 8'd1:
        shift_word <= audio_valid ? frame_slots.left : '0;
      slot_right_first - 8'd1:
        shift_word <= audio_valid ? frame_slots.right : '0;
      default:
        shift_word <= {shift_word[18:0], 1'b0};
    endcase
  end

  always_ff @(posedge ac97_bit_clock) begin
    if (engine_reset) begin
      ac97_sdata_out <= 1'b0;
    end else if (bit_count < sync_bits) begin
      // slot 0 tags
      case (bit_count)
        8'd0:       ac97_sdata_out <= 1'b1;
        8'd1, 8'd2: ac97_sdata_out <= frame_slots.cmd.valid;
        8'd3, 8'd4: ac97_sdata_out <= audio_valid;
        default:    ac97_sdata_out <= 1'b0;
      endcase
    end else if (bit_count < slot_right_first + slot_bits) begin
      ac97_sdata_out <= shift_word[19];
    end else begin
      // slots 5 to 12 unused
      ac97_sdata_out <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // capture on falling edge
  ////////////////////////////////////////////////////////////

  always_ff @(negedge ac97_bit_clock) begin
    // codec data lags our counter by one bit
    if (bit_count > slot_left_first && bit_count <= slot_right_first) begin
      slots_in.left <= {slots_in.left[18:0], ac97_sdata_in};
    end else if (bit_count > slot_right_first &&
                 bit_count <= slot_right_first + slot_bits) begin
      slots_in.right <= {slots_in.right[18:0], ac97_sdata_in};
    end
  end

endmodule

// ==== src/ac97_audio_top.sv ====
`timescale 1ns/1ns

module ac97_audio_top #(
  parameter ac97_pkg::debounce_count_t debounce_cycles = ac97_pkg::debounce_cycles_default
) (
  input  logic                    clock_27mhz,
  input  logic                    reset,
  input  logic                    button_up,
  input  logic                    button_down,
  // [1] left, [0] right
  input  ac97_pkg::sample_t [1:0] play_sample,
  output ac97_pkg::sample_t [1:0] capture_sample,
  output logic                    frame_strobe,
  output ac97_pkg::volume_t       volume,
  output logic                    audio_reset_b,
  output logic                    ac97_sdata_out,
  input  logic                    ac97_sdata_in,
  output logic                    ac97_synch,
  input  logic                    ac97_bit_clock
);

  import ac97_pkg::*;

  reset_count_t reset_count;
  logic [2:0]   ready_sync;
  logic         frame_ready;
  sample_t      play_left;
  sample_t      play_right;
  codec_cmd_t   command;
  slot_out_t    slots_out;
  slot_in_t     slots_in;

  // hold the codec in reset a while after ours
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      audio_reset_b <= 1'b0;
      reset_count   <= '0;
    end else if (reset_count == reset_count_t'(codec_reset_cycles - 1)) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  // ready crosses from bit clock, strobe on its rise
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[1:0], frame_ready};
    end
  end

  assign frame_strobe = ready_sync[1] & ~ready_sync[2];

  // playback words sampled once per frame
  always_ff @(posedge clock_27mhz) begin
    if (frame_strobe) begin
      play_left  <= play_sample[1];
      play_right <= play_sample[0];
    end
  end

  assign slots_out.cmd   = command;
  assign slots_out.left  = {play_left, 2'b00};
  assign slots_out.right = {play_right, 2'b00};

  // top 18 of each 20-bit capture slot
  assign capture_sample[1] = slots_in.left[19:2];
  assign capture_sample[0] = slots_in.right[19:2];

  volume_control #(.debounce_cycles(debounce_cycles)) i_volume_control (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .button_up   (button_up),
    .button_down (button_down),
    .volume      (volume)
  );

  codec_command_sequencer i_codec_command_sequencer (
    .clock_27mhz  (clock_27mhz),
    .reset        (reset),
    .frame_strobe (frame_strobe),
    .volume       (volume),
    .command      (command)
  );

  ac97_frame_engine i_ac97_frame_engine (
    .ac97_bit_clock (ac97_bit_clock),
    .reset          (reset),
    .slots_out      (slots_out),
    .slots_in       (slots_in),
    .frame_ready    (frame_ready),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch)
  );

endmodule

// ==== bench/ac97_audio_props.sv ====
`timescale 1ns/1ns

module ac97_audio_props (
  input logic clock_27mhz,
  input logic reset,
  input logic frame_strobe,
  input logic ac97_bit_clock,
  input logic ac97_synch
);

  import ac97_pkg::*;

  // bit clocks synch has been high so far
  logic [7:0]  synch_high;
  // cycles since the last strobe, saturating
  logic [10:0] strobe_gap;

  always_ff @(posedge ac97_bit_clock) begin
    if (reset) begin
      synch_high <= '0;
    end else if (ac97_synch) begin
      synch_high <= synch_high + 8'd1;
    end else begin
      synch_high <= '0;
    end
  end

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      strobe_gap <= '1;
    end else if (frame_strobe) begin
      strobe_gap <= '0;
    end else if (strobe_gap != '1) begin
      strobe_gap <= strobe_gap + 11'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // strobe is a single-cycle pulse
  ////////////////////////////////////////////////////////////

  // one strobe per frame, a frame is about 1050 cycles
  strobe_single : assert property (
    @(posedge clock_27mhz) disable iff (reset) frame_strobe |-> strobe_gap >= 11'd900
  ) else $error("frame_strobe %0d cycles after the previous one", strobe_gap);

  // synch pulse width in bit clocks
  synch_width : assert property (
    @(posedge ac97_bit_clock) disable iff (reset) $fell(ac97_synch) |-> synch_high == sync_bits
  ) else $error("ac97_synch high for %0d bit clocks", synch_high);

endmodule

bind ac97_audio_top ac97_audio_props i_props (.*);

// ==== bench/ac97_audio_tb.sv ====
`timescale 1ns/1ns

module ac97_audio_tb;

  import ac97_pkg::*;

  logic              clock_27mhz;
  logic              reset;
  logic              button_up;
  logic              button_down;
  sample_t     [1:0] play_sample;
  sample_t     [1:0] capture_sample;
  logic              frame_strobe;
  volume_t           volume;
  logic              audio_reset_b;
  logic              ac97_sdata_out;
  logic              ac97_sdata_in;
  logic              ac97_synch;
  logic              ac97_bit_clock;

  integer      seed;
  logic [31:0] rnd;
  int          errors = 0;
  int          checks = 0;
  int          tests_done = 0;
  // model of the volume register
  volume_t     exp_volume;

  // codec model state
  int          idx = 0;
  int          sync_count = 0;
  int          frames_seen = 0;
  int          headphone_seen = 0;
  int          commands_checked = 0;
  logic        synch_prev = 1'b0;
  logic        cmd_check_on = 1'b0;
  logic [255:0] fbits;
  logic [4:0]  last_tags;
  slot_word_t  last_left;
  slot_word_t  last_right;
  slot_word_t  cap_left = '0;
  slot_word_t  cap_right = '0;
  slot_word_t  cap_done_left;
  slot_word_t  cap_done_right;
  logic        cap_done_valid = 1'b0;

  ac97_audio_top #(.debounce_cycles(19'd20)) i_dut (.*);

  always #10 clock_27mhz = ~clock_27mhz;
  always #41 ac97_bit_clock = ~ac97_bit_clock;

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic report_test(input string name);
    tests_done++;
    $display("test %s done, errors so far %0d", name, errors);
  endtask

  // bit 0 of the frame is the first bit after synch rises
  function automatic slot_word_t slot_word(input int first);
    slot_word_t w;
    for (int i = 0; i < 20; i++) begin
      w[19 - i] = fbits[first + i];
    end
    return w;
  endfunction

  // codec register table, attenuation is 31 minus volume
  function automatic bit command_known(input cmd_addr_t a, input cmd_data_t d,
                                       input volume_t v);
    volume_t att;
    att = 5'd31 - v;
    case (a)
      8'h80:   return d == 16'h0000;
      8'h04:   return d == {3'b000, att, 3'b000, att};
      8'h18:   return d == 16'h0808;
      8'h1A:   return d == 16'h0404;
      8'h1C:   return d == 16'h0F0F;
      8'h0E:   return d == 16'h8048;
      8'h0A:   return d == 16'h0000;
      8'h20:   return d == 16'h8000;
      default: return 1'b0;
    endcase
  endfunction

  task automatic decode_frame;
    slot_word_t addr_w;
    slot_word_t data_w;
    frames_seen++;
    check(sync_count == 16, "synch not high for 16 bits");
    check(fbits[0] == 1'b1, "frame valid tag clear");
    check(fbits[255:96] == '0, "bits after slot 4 not zero");
    last_tags  = fbits[4:0];
    last_left  = slot_word(56);
    last_right = slot_word(76);
    if (cmd_check_on && fbits[1] && fbits[2]) begin
      addr_w = slot_word(16);
      data_w = slot_word(36);
      commands_checked++;
      check(command_known(addr_w[19:12], data_w[19:4], exp_volume), "unknown codec command");
      if (addr_w[19:12] == 8'h04) begin
        headphone_seen++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // codec model, counts bits from the synch rise
  ////////////////////////////////////////////////////////////

  always @(negedge ac97_bit_clock) begin
    if (idx >= 1 && idx <= 256) begin
      fbits[idx - 1] = ac97_sdata_out;
    end
    if (idx == 256) begin
      decode_frame();
    end
    // both capture slots shifted in by now
    if (idx == 97) begin
      cap_done_left  = cap_left;
      cap_done_right = cap_right;
      cap_done_valid = 1'b1;
    end
    if (ac97_synch && !synch_prev) begin
      idx        = 1;
      sync_count = 1;
    end else if (idx >= 1 && idx <= 256) begin
      if (ac97_synch && idx < 256) begin
        sync_count++;
      end
      idx++;
    end
    synch_prev = ac97_synch;
  end

  // capture words, msb first
  always @(posedge ac97_bit_clock) begin
    if (idx == 1) begin
      // fresh capture words for this frame
      cap_left  = slot_word_t'($random(seed));
      cap_right = slot_word_t'($random(seed));
    end
    if (idx >= 57 && idx <= 76) begin
      ac97_sdata_in <= cap_left[76 - idx];
    end else if (idx >= 77 && idx <= 96) begin
      ac97_sdata_in <= cap_right[96 - idx];
    end else begin
      ac97_sdata_in <= 1'b0;
    end
  end

  task automatic wait_strobe;
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock_27mhz);
      cycles++;
    end while (!frame_strobe && cycles < 3000);
    if (!frame_strobe) begin
      fail_timeout("frame_strobe");
    end
  endtask

  // hold one button low, then release long enough to settle
  task automatic press_button(input bit up, input int len);
    for (int i = 0; i < len; i++) begin
      @(posedge clock_27mhz);
      button_up   <= up ? 1'b0 : 1'b1;
      button_down <= up ? 1'b1 : 1'b0;
    end
    @(posedge clock_27mhz);
    button_up   <= 1'b1;
    button_down <= 1'b1;
    repeat (30) @(posedge clock_27mhz);
  endtask

  task automatic wait_volume(input volume_t expected);
    int cycles;
    cycles = 0;
    while (volume != expected && cycles < 100) begin
      @(negedge clock_27mhz);
      cycles++;
    end
    check(volume == expected, $sformatf("volume %0d, expected %0d", volume, expected));
  endtask

  initial begin
    int      cycles;
    sample_t left;
    sample_t right;
    bit      up;
    seed           = 32'hc1bd_306e;
    clock_27mhz    = 1'b0;
    ac97_bit_clock = 1'b0;
    reset          = 1'b1;
    button_up      = 1'b1;
    button_down    = 1'b1;
    play_sample    = '0;
    ac97_sdata_in  = 1'b0;

    ////////////////////////////////////////////////////////////
    // codec reset release
    ////////////////////////////////////////////////////////////
    for (int i = 0; i < 8; i++) begin
      @(negedge clock_27mhz);
      check(!audio_reset_b, "audio_reset_b high during reset");
    end
    @(posedge clock_27mhz);
    reset <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clock_27mhz);
      cycles++;
      @(negedge clock_27mhz);
    end while (!audio_reset_b && cycles < 5000);
    check(cycles == 1024, $sformatf("codec reset released after %0d cycles", cycles));
    check(volume == 5'd24, "volume after reset not 24");
    report_test("codec reset");

    // frame format is checked on every decoded frame
    cycles = 0;
    while (frames_seen < 4 && cycles < 20000) begin
      @(negedge clock_27mhz);
      cycles++;
    end
    if (frames_seen < 4) begin
      fail_timeout("decoded frames");
    end
    report_test("frame format");

    // playback, each pair held for three strobes
    for (int n = 0; n < 5; n++) begin
      wait_strobe();
      rnd   = $random(seed);
      left  = rnd[17:0];
      rnd   = $random(seed);
      right = rnd[17:0];
      @(posedge clock_27mhz);
      play_sample <= {left, right};
      repeat (3) wait_strobe();
      check(last_left == {left, 2'b00}, "slot 3 word mismatch");
      check(last_right == {right, 2'b00}, "slot 4 word mismatch");
      check(last_tags[4:3] == 2'b11, "left or right tag clear");
    end
    report_test("playback");

    // capture words land by the strobe of the same frame
    for (int n = 0; n < 8; n++) begin
      wait_strobe();
      if (cap_done_valid) begin
        check(capture_sample[1] == cap_done_left[19:2], "left capture mismatch");
        check(capture_sample[0] == cap_done_right[19:2], "right capture mismatch");
      end
    end
    report_test("capture");

    ////////////////////////////////////////////////////////////
    // volume stepping and saturation
    ////////////////////////////////////////////////////////////
    exp_volume = 5'd24;
    for (int n = 0; n < 60; n++) begin
      // up first to hit 31, then down to hit 0, then mixed
      up = (n < 10) ? 1'b1 : (n < 45) ? 1'b0 : rnd[5];
      rnd = $random(seed);
      if (rnd[7:6] == 2'b00) begin
        // short bounce, no step expected
        press_button(up, 3 + int'(rnd[3:0]));
        wait_volume(exp_volume);
      end
      press_button(up, 25 + int'(rnd[4:0]));
      if (up && exp_volume != 5'd31) begin
        exp_volume = exp_volume + 5'd1;
      end else if (!up && exp_volume != 5'd0) begin
        exp_volume = exp_volume - 5'd1;
      end
      wait_volume(exp_volume);
    end
    report_test("volume stepping");

    // a full pass through the sequencer table
    cmd_check_on = 1'b1;
    repeat (20) wait_strobe();
    cmd_check_on = 1'b0;
    check(commands_checked >= 16, "too few command frames decoded");
    check(headphone_seen > 0, "no headphone command seen");
    report_test("commands");

    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/ac97_pkg.sv
src/switch_debounce.sv
src/volume_control.sv
src/codec_command_sequencer.sv
src/ac97_frame_engine.sv
src/ac97_audio_top.sv
bench/ac97_audio_props.sv
bench/ac97_audio_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = ac97_audio_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets: test clean help"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
